// File: Bender.yml
package:
  name: video_timing

dependencies: {}

sources:
  - common/video_timing_pkg.sv
  - common/host_regs_pkg.sv
  - host_regs/host_reg_bank.sv
  - sync_gen/sync_generator.sv
  - logic/video_out_stage.sv
  - logic/video_timing_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_video_timing.sv

// File: common/host_regs_pkg.sv
package host_regs_pkg;

   import video_timing_pkg::*;

   // ***********************************************************
   // Host register map
   // ***********************************************************

   localparam int REG_ADDR_W = 5;          // 32 byte addresses, 20 decoded.

   // Timing values are 16 bit, high byte first.
   typedef enum logic [REG_ADDR_W-1:0] {
      REG_H_RES_HI   = 5'd0,
      REG_H_RES_LO   = 5'd1,
      REG_H_FRONT_HI = 5'd2,
      REG_H_FRONT_LO = 5'd3,
      REG_H_SYNC_HI  = 5'd4,
      REG_H_SYNC_LO  = 5'd5,
      REG_H_BACK_HI  = 5'd6,
      REG_H_BACK_LO  = 5'd7,
      REG_V_RES_HI   = 5'd8,
      REG_V_RES_LO   = 5'd9,
      REG_V_FRONT_HI = 5'd10,
      REG_V_FRONT_LO = 5'd11,
      REG_V_SYNC_HI  = 5'd12,
      REG_V_SYNC_LO  = 5'd13,
      REG_V_BACK_HI  = 5'd14,
      REG_V_BACK_LO  = 5'd15,
      REG_CTRL       = 5'd16,              // Video enable and sync polarity.
      REG_BG_RED     = 5'd17,
      REG_BG_GREEN   = 5'd18,
      REG_BG_BLUE    = 5'd19
   } reg_addr_e;

   // One host write, taken whenever the strobe is high.
   typedef struct packed {
      reg_addr_e  addr;                    // Byte address.
      logic [7:0] data;                    // Byte to write.
   } host_wr_t;

   // REG_CTRL layout, bit 0 in the lowest position.
   typedef struct packed {
      logic vs_invert;                     // Bit 2, 1 gives active-low vsync.
      logic hs_invert;                     // Bit 1, 1 gives active-low hsync.
      logic video_en;                      // Bit 0, display enable gate.
   } ctrl_t;

   // Video off, both syncs active low.
   localparam ctrl_t CTRL_RESET = '{vs_invert: 1'b1, hs_invert: 1'b1, video_en: 1'b0};

   localparam rgb_t BG_RESET = '{red: 8'h00, green: 8'h00, blue: 8'h00};  // Black.

endpackage

// File: common/video_timing_pkg.sv
package video_timing_pkg;

   // ***********************************************************
   // Raster timing
   // ***********************************************************

   localparam int TIMING_W = 16;           // Width of every timing field.

   // Horizontal fields in pixels, vertical fields in lines.
   typedef struct packed {
      logic [TIMING_W-1:0] h_res;          // Visible pixels per line.
      logic [TIMING_W-1:0] h_front;        // Front porch.
      logic [TIMING_W-1:0] h_sync;         // Hsync width.
      logic [TIMING_W-1:0] h_back;         // Back porch.
      logic [TIMING_W-1:0] v_res;          // Visible lines per frame.
      logic [TIMING_W-1:0] v_front;        // Front porch.
      logic [TIMING_W-1:0] v_sync;         // Vsync height.
      logic [TIMING_W-1:0] v_back;         // Back porch.
   } timing_t;

   // 640x480 at 60 Hz, 800 x 525 total.
   localparam timing_t TIMING_DEFAULT = '{
      h_res:   16'd640,
      h_front: 16'd16,
      h_sync:  16'd96,
      h_back:  16'd48,
      v_res:   16'd480,
      v_front: 16'd10,
      v_sync:  16'd2,
      v_back:  16'd33
   };

   // ***********************************************************
   // Raster and colour
   // ***********************************************************

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // Raw raster from the sync generator, all active high.
   typedef struct packed {
      logic hde;                           // Inside visible pixels of a line.
      logic vde;                           // Inside visible lines of a frame.
      logic hsync;                         // Hsync window, no polarity applied.
      logic vsync;                         // Vsync window, no polarity applied.
      logic pix_clk;                       // Pixel clock, high in first half of period.
   } raster_t;

endpackage

// File: flist.f
common/video_timing_pkg.sv
common/host_regs_pkg.sv
host_regs/host_reg_bank.sv
sync_gen/sync_generator.sv
logic/video_out_stage.sv
logic/video_timing_top.sv
verification/tb_clock_gen.sv
verification/tb_video_timing.sv

// File: host_regs/host_reg_bank.sv
module host_reg_bank import host_regs_pkg::*, video_timing_pkg::*; (
   input  logic     clk_2x,
   input  logic     rst_n,
   input  host_wr_t host_wr,               // Address and data of a write.
   input  logic     host_wr_en,            // Write strobe, one byte per cycle.
   output timing_t  timing,                // Live timing, shadowed by the sync generator.
   output ctrl_t    ctrl,
   output rgb_t     bg
);

   timing_t timing_q;                      // Sixteen timing bytes.
   ctrl_t   ctrl_q;                        // REG_CTRL.
   rgb_t    bg_q;                          // Three colour bytes.

   // ***********************************************************
   // Byte write decode
   // ***********************************************************

   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         timing_q <= TIMING_DEFAULT;       // Bank comes up at 640x480.
         ctrl_q   <= CTRL_RESET;
         bg_q     <= BG_RESET;
      end else if (host_wr_en) begin
         case (host_wr.addr)
            // High and low bytes land in the two halves of each field.
            REG_H_RES_HI:   timing_q.h_res[15:8]   <= host_wr.data;
            REG_H_RES_LO:   timing_q.h_res[7:0]    <= host_wr.data;
            REG_H_FRONT_HI: timing_q.h_front[15:8] <= host_wr.data;
            REG_H_FRONT_LO: timing_q.h_front[7:0]  <= host_wr.data;
            REG_H_SYNC_HI:  timing_q.h_sync[15:8]  <= host_wr.data;
            REG_H_SYNC_LO:  timing_q.h_sync[7:0]   <= host_wr.data;
            REG_H_BACK_HI:  timing_q.h_back[15:8]  <= host_wr.data;
            REG_H_BACK_LO:  timing_q.h_back[7:0]   <= host_wr.data;
            REG_V_RES_HI:   timing_q.v_res[15:8]   <= host_wr.data;
            REG_V_RES_LO:   timing_q.v_res[7:0]    <= host_wr.data;
            REG_V_FRONT_HI: timing_q.v_front[15:8] <= host_wr.data;
            REG_V_FRONT_LO: timing_q.v_front[7:0]  <= host_wr.data;
            REG_V_SYNC_HI:  timing_q.v_sync[15:8]  <= host_wr.data;
            REG_V_SYNC_LO:  timing_q.v_sync[7:0]   <= host_wr.data;
            REG_V_BACK_HI:  timing_q.v_back[15:8]  <= host_wr.data;
            REG_V_BACK_LO:  timing_q.v_back[7:0]   <= host_wr.data;
            REG_CTRL:       ctrl_q     <= ctrl_t'(host_wr.data[2:0]);  // Upper bits dropped.
            REG_BG_RED:     bg_q.red   <= host_wr.data;
            REG_BG_GREEN:   bg_q.green <= host_wr.data;
            REG_BG_BLUE:    bg_q.blue  <= host_wr.data;
            default: ;                     // Addresses 20 to 31 do nothing.
         endcase
      end
   end

   // ***********************************************************
   // Outputs
   // ***********************************************************

   assign timing = timing_q;               // Visible one edge after the strobe.
   assign ctrl   = ctrl_q;
   assign bg     = bg_q;

endmodule

// File: logic/video_out_stage.sv
module video_out_stage import host_regs_pkg::*, video_timing_pkg::*; (
   input  logic    clk_2x,
   input  logic    rst_n,
   input  raster_t raster,                 // Raw raster from the sync generator.
   input  ctrl_t   ctrl,                   // Polarity and video enable.
   input  rgb_t    bg,                     // Background colour.
   output logic    hs,
   output logic    vs,
   output logic    vde,
   output logic    pixel_clk,
   output rgb_t    rgb
);

   logic de;                               // Display area with video enabled.
   logic hs_q;
   logic vs_q;
   logic vde_q;
   logic pixel_clk_q;
   rgb_t rgb_q;

   assign de = raster.hde & raster.vde & ctrl.video_en;

   // ***********************************************************
   // Output register stage
   // ***********************************************************

   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         hs_q        <= CTRL_RESET.hs_invert;  // Inactive sync level.
         vs_q        <= CTRL_RESET.vs_invert;
         vde_q       <= 1'b0;
         pixel_clk_q <= 1'b0;
         rgb_q       <= '0;
      end else begin
         hs_q        <= raster.hsync ^ ctrl.hs_invert;
         vs_q        <= raster.vsync ^ ctrl.vs_invert;
         vde_q       <= de;
         pixel_clk_q <= raster.pix_clk;
         rgb_q       <= de ? bg : '0;     // Blank outside the display area.
      end
   end

   assign hs        = hs_q;
   assign vs        = vs_q;
   assign vde       = vde_q;
   assign pixel_clk = pixel_clk_q;        // Same delay as the data.
   assign rgb       = rgb_q;

endmodule

// File: logic/video_timing_top.sv
module video_timing_top import host_regs_pkg::*, video_timing_pkg::*; #(
   parameter int PIX_DIV = 4               // clk_2x cycles per pixel.
) (
   input  logic     clk_2x,
   input  logic     rst_n,
   input  host_wr_t host_wr,
   input  logic     host_wr_en,
   output logic     hs,
   output logic     vs,
   output logic     vde,
   output logic     pixel_clk,
   output rgb_t     rgb
);

   timing_t timing;                        // Register bank to sync generator.
   ctrl_t   ctrl;                          // Register bank to output stage.
   rgb_t    bg;
   raster_t raster;                        // Sync generator to output stage.

   // ***********************************************************
   // Host side
   // ***********************************************************

   host_reg_bank u_regs (
      .clk_2x     ( clk_2x     ),
      .rst_n      ( rst_n      ),
      .host_wr    ( host_wr    ),
      .host_wr_en ( host_wr_en ),
      .timing     ( timing     ),
      .ctrl       ( ctrl       ),
      .bg         ( bg         )
   );

   sync_generator #(
      .PIX_DIV ( PIX_DIV )
   ) u_sync (
      .clk_2x ( clk_2x ),
      .rst_n  ( rst_n  ),
      .timing ( timing ),
      .raster ( raster )                   // Registered raster.
   );

   // Video port, second register stage.
   video_out_stage u_out (
      .clk_2x    ( clk_2x    ),
      .rst_n     ( rst_n     ),
      .raster    ( raster    ),
      .ctrl      ( ctrl      ),
      .bg        ( bg        ),
      .hs        ( hs        ),
      .vs        ( vs        ),
      .vde       ( vde       ),
      .pixel_clk ( pixel_clk ),
      .rgb       ( rgb       )
   );

endmodule

// File: sync_gen/sync_generator.sv
module sync_generator import video_timing_pkg::*; #(
   parameter int PIX_DIV = 4               // clk_2x cycles per pixel, even, 2 or more.
) (
   input  logic    clk_2x,
   input  logic    rst_n,
   input  timing_t timing,                 // Live registers from the host bank.
   output raster_t raster                  // Registered raster, one cycle after the counters.
);

   localparam int PHASE_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
   localparam int SUM_W   = TIMING_W + 2;  // Room for the sum of four fields.

   logic [PHASE_W-1:0]  phase;             // Position inside one pixel period.
   logic                pix_en;
   timing_t             shadow;            // Timing in use for this frame.
   logic [TIMING_W-1:0] h_cnt;
   logic [TIMING_W-1:0] v_cnt;
   logic [SUM_W-1:0]    h_pos;
   logic [SUM_W-1:0]    v_pos;
   logic [SUM_W-1:0]    h_sync_start;
   logic [SUM_W-1:0]    h_sync_end;
   logic [SUM_W-1:0]    h_total;
   logic [SUM_W-1:0]    v_sync_start;
   logic [SUM_W-1:0]    v_sync_end;
   logic [SUM_W-1:0]    v_total;
   logic                h_last;
   logic                v_last;
   raster_t             raster_d;
   raster_t             raster_q;

   // True while lo <= cnt < hi. Shared by the h and v decoders.
   function automatic logic in_window(
      input logic [SUM_W-1:0] cnt,
      input logic [SUM_W-1:0] lo,
      input logic [SUM_W-1:0] hi
   );
      return (cnt >= lo) && (cnt < hi);
   endfunction

   // ***********************************************************
   // Pixel enable divider
   // ***********************************************************

   assign pix_en = (phase == PHASE_W'(PIX_DIV - 1));  // Last cycle of the pixel.

   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         phase <= '0;
      end else if (pix_en) begin
         phase <= '0;                      // Wrap for any even divider.
      end else begin
         phase <= phase + 1'b1;
      end
   end

   // ***********************************************************
   // Window edges from the shadowed timing
   // ***********************************************************

   always_comb begin
      h_sync_start = SUM_W'(shadow.h_res) + SUM_W'(shadow.h_front);
      h_sync_end   = h_sync_start + SUM_W'(shadow.h_sync);
      h_total      = h_sync_end + SUM_W'(shadow.h_back);
      v_sync_start = SUM_W'(shadow.v_res) + SUM_W'(shadow.v_front);
      v_sync_end   = v_sync_start + SUM_W'(shadow.v_sync);
      v_total      = v_sync_end + SUM_W'(shadow.v_back);
   end

   assign h_pos  = {2'b00, h_cnt};
   assign v_pos  = {2'b00, v_cnt};
   assign h_last = (h_pos >= h_total - 1'b1);  // Also catches an overrun.
   assign v_last = (v_pos >= v_total - 1'b1);

   // ***********************************************************
   // Counters and frame boundary shadow
   // ***********************************************************

   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (pix_en) begin
         if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // Line step on h wrap.
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // New host timing only lands on the last pixel of the frame.
   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         shadow <= TIMING_DEFAULT;
      end else if (pix_en && h_last && v_last) begin
         shadow <= timing;
      end
   end

   // ***********************************************************
   // Decode and output register
   // ***********************************************************

   always_comb begin
      raster_d.hde     = in_window(h_pos, '0, SUM_W'(shadow.h_res));
      raster_d.vde     = in_window(v_pos, '0, SUM_W'(shadow.v_res));
      raster_d.hsync   = in_window(h_pos, h_sync_start, h_sync_end);
      raster_d.vsync   = in_window(v_pos, v_sync_start, v_sync_end);
      raster_d.pix_clk = (phase < PHASE_W'(PIX_DIV / 2));  // High for first half.
   end

   always_ff @(posedge clk_2x) begin
      if (!rst_n) begin
         raster_q <= '0;                   // No display, no sync, clock low.
      end else begin
         raster_q <= raster_d;
      end
   end

   assign raster = raster_q;

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
   output logic clk_2x,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_PERIOD  = 5;        // 10 ns clock.
   localparam int RESET_CYCLES = 5;

   initial begin
      clk_2x = 1'b0;
      forever #(HALF_PERIOD) clk_2x = ~clk_2x;
   end

   // Released on a rising edge, so the DUT sees exactly five reset edges.
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_2x);
      rst_n <= 1'b1;
   end

endmodule

// File: verification/tb_video_timing.sv
module tb_video_timing import host_regs_pkg::*, video_timing_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int     PIX_DIV       = 4;
   localparam longint CLK_PERIOD_NS = 10;

   // ***********************************************************
   // Expected rasters
   // ***********************************************************

   localparam int DEF_H_SYNC    = 96;      // 640x480 default.
   localparam int DEF_H_TOTAL   = 640 + 16 + 96 + 48;
   localparam int DEF_V_SYNC    = 2;
   localparam int DEF_V_TOTAL   = 480 + 10 + 2 + 33;
   localparam int DEF_FRAME_PIX = DEF_H_TOTAL * DEF_V_TOTAL;
   localparam int SM_H_RES      = 8;       // Small raster, reprogrammed.
   localparam int SM_H_SYNC     = 3;
   localparam int SM_H_TOTAL    = SM_H_RES + 2 + SM_H_SYNC + 2;
   localparam int SM_V_RES      = 4;
   localparam int SM_V_SYNC     = 1;
   localparam int SM_V_TOTAL    = SM_V_RES + 1 + SM_V_SYNC + 1;
   localparam int SM_FRAME_PIX  = SM_H_TOTAL * SM_V_TOTAL;
   localparam longint WATCHDOG_NS =
      3 * longint'(DEF_FRAME_PIX) * PIX_DIV * CLK_PERIOD_NS + 2_000_000;

   localparam timing_t SMALL_TIMING = '{
      h_res: 16'd8, h_front: 16'd2, h_sync: 16'd3, h_back: 16'd2,
      v_res: 16'd4, v_front: 16'd1, v_sync: 16'd1, v_back: 16'd1
   };
   localparam rgb_t BLANK = '{red: 8'h00, green: 8'h00, blue: 8'h00};

   logic        clk_2x;
   logic        rst_n;
   host_wr_t    host_wr;
   logic        host_wr_en;
   logic        hs;
   logic        vs;
   logic        vde;
   logic        pixel_clk;
   rgb_t        rgb;
   logic [31:0] lcg_state = 32'd41;        // Seed.

   tb_clock_gen u_clk (
      .clk_2x ( clk_2x ),
      .rst_n  ( rst_n  )
   );

   video_timing_top #(
      .PIX_DIV ( PIX_DIV )
   ) uut (
      .clk_2x     ( clk_2x     ),
      .rst_n      ( rst_n      ),
      .host_wr    ( host_wr    ),
      .host_wr_en ( host_wr_en ),
      .hs         ( hs         ),
      .vs         ( vs         ),
      .vde        ( vde        ),
      .pixel_clk  ( pixel_clk  ),
      .rgb        ( rgb        )
   );

   // ***********************************************************
   // Helpers and checks
   // ***********************************************************

   function automatic logic [7:0] random_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];             // Middle bits, better spread.
   endfunction

   task automatic stop_on_failure();
      $display("Something failed");
      $fatal(1, "Stopped at the first failure");
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error: %s expected 0x%0h, actual 0x%0h", name, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic compare_rgb(input string name, input rgb_t exp, input rgb_t act);
      if (act !== exp) begin
         $display("Error: %s expected 0x%06h, actual 0x%06h", name, exp, act);
         stop_on_failure();
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      if (act !== exp) begin
         $display("Error: %s expected 0x%0h, actual 0x%0h", name, exp, act);
         stop_on_failure();
      end
   endtask

   // One byte write, strobe high for a single cycle.
   task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
      @(posedge clk_2x);
      host_wr    <= '{addr: addr, data: data};
      host_wr_en <= 1'b1;
      @(posedge clk_2x);
      host_wr_en <= 1'b0;
   endtask

   task automatic write_timing(input timing_t t);
      logic [TIMING_W-1:0] field;
      for (int i = 0; i < 8; i++) begin
         field = t[(7 - i) * TIMING_W +: TIMING_W];  // h_res in the top bits.
         write_reg(reg_addr_e'(2 * i), field[15:8]);
         write_reg(reg_addr_e'(2 * i + 1), field[7:0]);
      end
   endtask

   // Returns at the first falling clk_2x edge of the next pixel.
   task automatic wait_pixel();
      int guard;
      guard = 0;
      do begin
         @(negedge clk_2x);
         guard++;
      end while (pixel_clk !== 1'b0 && guard < 4 * PIX_DIV);
      do begin
         @(negedge clk_2x);
         guard++;
      end while (pixel_clk !== 1'b1 && guard < 4 * PIX_DIV);
      if (guard >= 4 * PIX_DIV) begin
         $display("pixel_clk stopped toggling");
         stop_on_failure();
      end
   endtask

   // From one sync pulse start to the next, counted in pixels.
   task automatic measure_pulse(input bit use_vs, input logic act, input int limit,
                                output int width, output int period,
                                output int de_pix, output int de_runs);
      logic cur;
      logic prev;
      logic de_prev;
      bit   in_pulse;
      int   n;
      wait_pixel();
      prev = use_vs ? vs : hs;
      n    = 0;
      forever begin
         wait_pixel();
         cur = use_vs ? vs : hs;
         if (cur === act && prev !== act) break;  // Pulse start.
         prev = cur;
         n++;
         if (n > limit) begin
            $display("No sync pulse start found on %s", use_vs ? "vs" : "hs");
            stop_on_failure();
         end
      end
      width    = 1;
      period   = 1;
      in_pulse = 1'b1;
      de_pix   = (vde === 1'b1);
      de_runs  = (vde === 1'b1);
      de_prev  = vde;
      prev     = cur;
      forever begin
         wait_pixel();
         cur = use_vs ? vs : hs;
         if (cur === act && prev !== act) break;
         if (in_pulse && cur === act) width++;
         else in_pulse = 1'b0;
         period++;
         if (vde === 1'b1) de_pix++;
         if (vde === 1'b1 && de_prev !== 1'b1) de_runs++;  // New display line.
         de_prev = vde;
         prev    = cur;
         if (period > limit) begin
            $display("Sync pulse on %s did not repeat", use_vs ? "vs" : "hs");
            stop_on_failure();
         end
      end
   endtask

   task automatic check_idle_outputs(input bit in_reset);
      compare_bit("vde", 1'b0, vde);
      compare_rgb("rgb", BLANK, rgb);
      compare_bit("hs", 1'b1, hs);
      compare_bit("vs", 1'b1, vs);
      if (in_reset) compare_bit("pixel_clk", 1'b0, pixel_clk);
   endtask

   // Every cycle of one small frame.
   task automatic check_frame_colour(input rgb_t exp_bg, input bit video_on);
      int seen;
      seen = 0;
      for (int i = 0; i < SM_FRAME_PIX * PIX_DIV; i++) begin
         @(negedge clk_2x);
         if (!video_on) compare_bit("vde", 1'b0, vde);
         if (vde === 1'b1) begin
            compare_rgb("rgb", exp_bg, rgb);
            seen++;
         end else begin
            compare_rgb("rgb", BLANK, rgb);  // Blanked outside display.
         end
      end
      if (video_on && seen == 0) begin
         $display("vde never went high while the colour was checked");
         stop_on_failure();
      end
   endtask

   // ***********************************************************
   // Directed tests
   // ***********************************************************

   task automatic test_reset_state();
      @(negedge clk_2x);
      while (rst_n !== 1'b1) begin
         check_idle_outputs(1'b1);
         @(negedge clk_2x);
      end
      repeat (4 * PIX_DIV) begin
         check_idle_outputs(1'b0);         // Still line 0, video off.
         @(negedge clk_2x);
      end
   endtask

   task automatic test_default_timing();
      int w;
      int p;
      int dp;
      int dr;
      measure_pulse(1'b0, 1'b0, 2 * DEF_H_TOTAL, w, p, dp, dr);
      compare_count("hs width", DEF_H_SYNC, w);
      compare_count("hs period", DEF_H_TOTAL, p);
      measure_pulse(1'b1, 1'b0, 2 * DEF_FRAME_PIX, w, p, dp, dr);
      compare_count("vs width", DEF_V_SYNC * DEF_H_TOTAL, w);
      compare_count("vs period", DEF_FRAME_PIX, p);
      compare_count("vde pixels", 0, dp);  // video_en is off after reset.
   endtask

   task automatic test_frame_reprogram();
      int w;
      int p;
      int dp;
      int dr;
      write_timing(SMALL_TIMING);
      write_reg(REG_CTRL, 8'h07);          // Video on, active-low syncs.
      measure_pulse(1'b1, 1'b0, 2 * DEF_FRAME_PIX, w, p, dp, dr);
      compare_count("vs width", SM_V_SYNC * SM_H_TOTAL, w);
      compare_count("vs period", SM_FRAME_PIX, p);
      compare_count("vde pixels", SM_H_RES * SM_V_RES, dp);
      compare_count("vde lines", SM_V_RES, dr);
      measure_pulse(1'b0, 1'b0, 4 * SM_H_TOTAL, w, p, dp, dr);
      compare_count("hs width", SM_H_SYNC, w);
      compare_count("hs period", SM_H_TOTAL, p);
   endtask

   task automatic test_polarity();
      int w;
      int p;
      int dp;
      int dr;
      write_reg(REG_CTRL, 8'h01);          // Both syncs high going.
      wait_pixel();
      wait_pixel();
      measure_pulse(1'b1, 1'b1, 4 * SM_FRAME_PIX, w, p, dp, dr);
      compare_count("vs width", SM_V_SYNC * SM_H_TOTAL, w);
      compare_count("vs period", SM_FRAME_PIX, p);
      measure_pulse(1'b0, 1'b1, 4 * SM_H_TOTAL, w, p, dp, dr);
      compare_count("hs width", SM_H_SYNC, w);
      compare_count("hs period", SM_H_TOTAL, p);
   endtask

   task automatic test_gating_colour();
      rgb_t colour;
      int   w;
      int   p;
      int   dp;
      int   dr;
      repeat (3) begin
         colour.red   = random_byte();
         colour.green = random_byte();
         colour.blue  = random_byte();
         write_reg(REG_BG_RED, colour.red);
         write_reg(REG_BG_GREEN, colour.green);
         write_reg(REG_BG_BLUE, colour.blue);
         wait_pixel();                     // Let the last byte reach rgb.
         check_frame_colour(colour, 1'b1);
      end
      write_reg(REG_CTRL, 8'h00);          // Video off, polarity unchanged.
      wait_pixel();
      check_frame_colour(colour, 1'b0);
      measure_pulse(1'b0, 1'b1, 4 * SM_H_TOTAL, w, p, dp, dr);
      compare_count("hs period", SM_H_TOTAL, p);
      compare_count("vde pixels", 0, dp);
   endtask

   // ***********************************************************
   // Run control
   // ***********************************************************

   initial begin
      host_wr    = '{addr: REG_H_RES_HI, data: 8'h00};
      host_wr_en = 1'b0;
      test_reset_state();
      test_default_timing();
      test_frame_reprogram();
      test_polarity();
      test_gating_colour();
      $display("Everything OK");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, the tests did not finish in time");
      stop_on_failure();
   end

endmodule
